// ==== msu_audio_if.f ====
+incdir+verilog
+incdir+tb
verilog/msu_pkg.sv
verilog/msu_bus_edge.sv
verilog/msu_mcu_sync.sv
verilog/msu_databuf.sv
verilog/msu_regs.sv
verilog/msu_top.sv
tb/msu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal -f msu_audio_if.f --top-module msu_tb -o msu_sim \
  && ./obj_dir/msu_sim > sim.log 2>&1 \
  || { echo "Build or simulation error"; exit 1; }
cat sim.log
grep -q "CHECKS FAILED" sim.log && exit 1 || exit 0

// ==== tb/msu_tb_ref.svh ====
`ifndef MSU_TB_REF_SVH
`define MSU_TB_REF_SVH

// Shadow state with flag bits in MCU update order
logic [5:0]             sh_flags;
logic                   sh_audio_start;
logic                   sh_data_start;
logic [2:0]             sh_audio_ctrl;
msu_play_t              sh_play;        // Latch bit stays 0 since checks come long after the pulse
logic [`MSU_BUF_AW-1:0] sh_buf_addr;
logic [7:0]             sh_mem [1 << `MSU_BUF_AW];

localparam logic [47:0] ID_TEXT = "S-MSU1";

function automatic void model_reset();
  sh_flags       = 6'b110000;  // Audio and data busy
  sh_audio_start = 1'b0;
  sh_data_start  = 1'b0;
  sh_audio_ctrl  = 3'd0;
  sh_play        = '0;
  sh_buf_addr    = '0;
endfunction

function automatic void model_write(input logic [2:0] a, input logic [7:0] d);
  case (a)
    3'd0, 3'd1, 3'd2, 3'd3: sh_play.addr[8*a +: 8] = d;  // Lowest byte first
    3'd4, 3'd5: sh_play.track[8*(a-4) +: 8] = d;
    3'd6: sh_play.volume = d;
    default: begin
      if (!sh_flags[5]) begin
        sh_audio_ctrl = d[2:0];
        sh_flags[0]   = 1'b1;
      end
    end
  endcase
  if (a == 3'd3) begin
    sh_data_start = 1'b1;
    sh_flags[4]   = 1'b1;
  end
  if (a == 3'd5) begin
    sh_audio_start = 1'b1;
    sh_flags[5]    = 1'b1;
  end
endfunction

// Set first, then reset wins
function automatic void model_update(input logic [5:0] set_b, input logic [5:0] rst_b);
  sh_flags = (sh_flags | set_b) & ~rst_b;
  if (rst_b[5]) sh_audio_start = 1'b0;
  if (rst_b[4]) sh_data_start = 1'b0;
endfunction

function automatic logic [7:0] model_read_data();
  logic [7:0] d;
  d           = sh_mem[sh_buf_addr];
  sh_buf_addr = sh_buf_addr + `MSU_BUF_AW'(1);  // Wraps at the buffer end
  return d;
endfunction

function automatic logic [7:0] exp_reg0();
  return {sh_flags[4], sh_flags[5], sh_flags[2:1], sh_flags[3], 3'd1};
endfunction

function automatic logic [7:0] exp_status();
  return {sh_buf_addr[`MSU_BUF_AW-1], sh_audio_start, sh_data_start, 1'b0,
          sh_audio_ctrl, sh_flags[0]};
endfunction

function automatic logic [7:0] id_byte(input int n);
  return ID_TEXT[8*(7-n) +: 8];  // Register 2 holds the first character
endfunction

`endif

// ==== tb/msu_tb.sv ====
`default_nettype none

`include "msu_settings.svh"

module msu_tb;

  import msu_pkg::*;

  // About 120 strobes of 15 cycles, plus reset and program port
  localparam int TEST_CYCLES = 120 * 15 + 200;
  localparam int MAX_CYCLES  = 3 * TEST_CYCLES;
  localparam int BUF_BASE    = 16350;  // Close to the buffer end

  logic                   clkin;
  logic                   rst_n;
  logic                   enable;
  logic                   reg_oe;
  logic                   reg_we;
  logic [2:0]             reg_addr;
  logic [7:0]             reg_data_in;
  wire  [7:0]             reg_data_out;
  logic [`MSU_BUF_AW-1:0] pgm_address;
  logic [7:0]             pgm_data;
  logic                   pgm_we;
  logic [`MSU_BUF_AW-1:0] addr_ext;
  logic                   addr_ext_write;
  logic [5:0]             status_set_bits;
  logic [5:0]             status_reset_bits;
  logic                   status_reset_we;
  wire  [7:0]             status_out;
  msu_play_t              play;

  int          seed = 82;
  int          rnd;
  int          checks = 0;
  int          errors = 0;
  int          cycles = 0;
  int          latch_count = 0;
  int          status_latch_count = 0;
  string       name_q[$];
  logic [63:0] exp_q[$];
  logic [63:0] got_q[$];

  `include "msu_tb_ref.svh"

  msu_top i_msu_top (.*);

  initial begin
    clkin = 1'b0;
    forever #5 clkin = ~clkin;
  end

  always @(posedge clkin) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout, run stopped after %0d cycles", cycles);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  ////////////////////
  // Checking
  ////////////////////

  task automatic compare_values(input string name, input logic [63:0] exp,
                                input logic [63:0] got);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch %s expected %0h got %0h", name, exp, got);
    end
  endtask

  task automatic queue_check(input string name, input logic [63:0] exp, input logic [63:0] got);
    name_q.push_back(name);
    exp_q.push_back(exp);
    got_q.push_back(got);
  endtask

  always @(posedge clkin) begin
    while (name_q.size() > 0) begin
      compare_values(name_q.pop_front(), exp_q.pop_front(), got_q.pop_front());
    end
  end

  always @(negedge clkin) begin
    if (play.volume_latch) latch_count++;  // Every cycle the pulse is high
    if (status_out[4]) status_latch_count++;
  end

  ////////////////////
  // Bus tasks
  ////////////////////

  task automatic bus_access(input logic wr, input logic [2:0] a, input logic [7:0] d,
                            output logic [7:0] q);
    @(posedge clkin);
    reg_addr    <= a;
    reg_data_in <= d;
    if (wr) reg_we <= 1'b1;
    else reg_oe <= 1'b1;
    repeat (6) @(posedge clkin);
    reg_we <= 1'b0;
    reg_oe <= 1'b0;
    @(negedge clkin);
    q = reg_data_out;
    repeat (8) @(posedge clkin);  // Address and data stay put for the end edge
    @(negedge clkin);
  endtask

  task automatic reg_write(input logic [2:0] a, input logic [7:0] d);
    logic [7:0] unused_q;
    bus_access(1'b1, a, d, unused_q);
  endtask

  task automatic write_random_byte(input logic [2:0] a);
    rnd = $random(seed);
    reg_write(a, rnd[7:0]);
    model_write(a, rnd[7:0]);
  endtask

  task automatic mcu_strobe(input logic is_seek, input logic [`MSU_BUF_AW-1:0] a,
                            input logic [5:0] set_b, input logic [5:0] rst_b);
    @(posedge clkin);
    addr_ext          <= a;  // Payload a cycle ahead of the strobe
    status_set_bits   <= set_b;
    status_reset_bits <= rst_b;
    @(posedge clkin);
    if (is_seek) addr_ext_write <= 1'b1;
    else status_reset_we <= 1'b1;
    repeat (6) @(posedge clkin);
    addr_ext_write  <= 1'b0;
    status_reset_we <= 1'b0;
    repeat (8) @(posedge clkin);
    @(negedge clkin);
    if (is_seek) sh_buf_addr = a;
    else model_update(set_b, rst_b);
  endtask

  task automatic check_state();
    logic [7:0] q;
    bus_access(1'b0, 3'd0, 8'h00, q);
    queue_check("reg_data_out", 64'(exp_reg0()), 64'(q));
    queue_check("status_out", 64'(exp_status()), 64'(status_out));
    queue_check("play", 64'(sh_play), 64'(play));
  endtask

  task automatic report_test(input int n, input string name);
    @(posedge clkin);
    @(negedge clkin);
    $display("Test %0d %s finished, %0d errors so far", n, name, errors);
  endtask

  ////////////////////
  // Tests
  ////////////////////

  initial begin
    logic [7:0] q;
    int         base;
    int         status_base;
    rst_n             <= 1'b0;
    enable            <= 1'b1;
    reg_oe            <= 1'b0;
    reg_we            <= 1'b0;
    reg_addr          <= 3'd0;
    reg_data_in       <= 8'h00;
    pgm_address       <= '0;
    pgm_data          <= 8'h00;
    pgm_we            <= 1'b1;
    addr_ext          <= '0;
    addr_ext_write    <= 1'b0;
    status_set_bits   <= 6'd0;
    status_reset_bits <= 6'd0;
    status_reset_we   <= 1'b0;
    model_reset();
    repeat (8) @(posedge clkin);
    rst_n <= 1'b1;
    @(negedge clkin);

    check_state();
    for (int i = 2; i < 8; i++) begin
      bus_access(1'b0, 3'(i), 8'h00, q);
      queue_check("reg_data_out", 64'(id_byte(i)), 64'(q));
    end
    report_test(1, "reset and identification");

    mcu_strobe(1'b0, '0, 6'h00, 6'h10);  // Data idle before the address write
    for (int i = 0; i < 4; i++) write_random_byte(3'(i));
    check_state();
    mcu_strobe(1'b0, '0, 6'h00, 6'h10);  // Data busy done
    check_state();
    report_test(2, "data address");

    mcu_strobe(1'b0, '0, 6'h00, 6'h20);  // Audio idle before the track write
    write_random_byte(3'd4);
    write_random_byte(3'd5);
    base        = latch_count;
    status_base = status_latch_count;
    write_random_byte(3'd6);
    queue_check("volume_latch cycles", 64'd1, 64'(latch_count - base));
    queue_check("status_out[4] cycles", 64'd1, 64'(status_latch_count - status_base));
    check_state();
    report_test(3, "track and volume");

    write_random_byte(3'd7);  // Locked out while audio is busy
    check_state();
    mcu_strobe(1'b0, '0, 6'h00, 6'h20);
    write_random_byte(3'd7);
    check_state();
    for (int i = 0; i < 8; i++) begin
      rnd = $random(seed);
      mcu_strobe(1'b0, '0, rnd[5:0], rnd[13:8]);
      check_state();
    end
    report_test(4, "control and status updates");

    for (int i = 0; i < 64; i++) begin
      rnd = $random(seed);
      @(posedge clkin);
      pgm_address <= `MSU_BUF_AW'(BUF_BASE + i);
      pgm_data    <= rnd[7:0];
      pgm_we      <= 1'b0;
      sh_mem[`MSU_BUF_AW'(BUF_BASE + i)] = rnd[7:0];
    end
    @(posedge clkin);
    pgm_we <= 1'b1;
    mcu_strobe(1'b1, `MSU_BUF_AW'(BUF_BASE), 6'h00, 6'h00);
    queue_check("status_out", 64'(exp_status()), 64'(status_out));
    for (int i = 0; i < 64; i++) begin
      bus_access(1'b0, 3'd1, 8'h00, q);
      queue_check("reg_data_out", 64'(model_read_data()), 64'(q));
      queue_check("status_out", 64'(exp_status()), 64'(status_out));
    end
    report_test(5, "buffer seek and read");

    @(posedge clkin);
    enable <= 1'b0;
    for (int i = 3; i < 8; i++) begin
      rnd = $random(seed);
      reg_write(3'(i), rnd[7:0]);  // Ignored and left out of the model
    end
    bus_access(1'b0, 3'd1, 8'h00, q);
    // Held from the last enabled read
    queue_check("reg_data_out", 64'(sh_mem[sh_buf_addr - 1'b1]), 64'(q));
    queue_check("play", 64'(sh_play), 64'(play));
    queue_check("status_out", 64'(exp_status()), 64'(status_out));
    @(posedge clkin);
    enable <= 1'b1;
    check_state();
    report_test(6, "disabled bus");

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/msu_bus_edge.sv ====
`default_nettype none

module msu_bus_edge (
  input  wire                clkin,
  input  wire                rst_n,
  input  wire                reg_oe,
  input  wire                reg_we,
  input  wire [2:0]          reg_addr,
  input  wire [7:0]          reg_data_in,
  output msu_pkg::msu_bus_t  bus
);

  import msu_pkg::*;

  logic [2:0] oe_sreg;  // Bit 0 is the newest sample
  logic [2:0] we_sreg;
  msu_bus_t   bus_d;

  // Strobes come from another clock domain
  always_ff @(posedge clkin) begin
    if (!rst_n) begin
      oe_sreg <= 3'b000;
      we_sreg <= 3'b000;
    end else begin
      oe_sreg <= {oe_sreg[1:0], reg_oe};
      we_sreg <= {we_sreg[1:0], reg_we};
    end
  end

  // Edges only from the two settled flops
  always_comb begin
    bus_d.addr     = reg_addr;
    bus_d.data     = reg_data_in;
    bus_d.rd_start = (oe_sreg[2:1] == 2'b01);
    bus_d.rd_end   = (oe_sreg[2:1] == 2'b10);
    bus_d.wr       = (we_sreg[2:1] == 2'b01);
  end

  // Pulse, address and data leave together
  always_ff @(posedge clkin) begin
    if (!rst_n) begin
      bus <= '0;
    end else begin
      bus <= bus_d;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/msu_databuf.sv ====
`default_nettype none

`include "msu_settings.svh"

module msu_databuf (
  input  wire                   clkin,
  input  wire                   pgm_we,       // Active low
  input  wire [`MSU_BUF_AW-1:0] pgm_address,
  input  wire [7:0]             pgm_data,
  input  wire [`MSU_BUF_AW-1:0] rd_address,
  output logic [7:0]            rd_data
);

  localparam int DEPTH = 1 << `MSU_BUF_AW;

  logic [7:0] mem [DEPTH];

  ////////////////////
  // Program port
  ////////////////////

  always_ff @(posedge clkin) begin
    if (!pgm_we) begin
      mem[pgm_address] <= pgm_data;
    end
  end

  ////////////////////
  // Read port
  ////////////////////

  // One cycle of latency, like a block RAM output register
  always_ff @(posedge clkin) begin
    rd_data <= mem[rd_address];
  end

endmodule

`default_nettype wire

// ==== verilog/msu_mcu_sync.sv ====
`default_nettype none

`include "msu_settings.svh"

module msu_mcu_sync (
  input  wire                            clkin,
  input  wire                            rst_n,
  input  wire                            addr_ext_write,
  input  wire [`MSU_BUF_AW-1:0]          addr_ext,
  input  wire                            status_reset_we,
  input  wire [5:0]                      status_set_bits,
  input  wire [5:0]                      status_reset_bits,
  output msu_pkg::msu_seek_t             seek,
  output msu_pkg::msu_status_upd_t       status_upd
);

  import msu_pkg::*;

  logic [2:0]      seek_sreg;  // Newest sample in bit 0
  logic [2:0]      upd_sreg;
  msu_seek_t       seek_d;
  msu_status_upd_t upd_d;

  always_ff @(posedge clkin) begin
    if (!rst_n) begin
      seek_sreg <= 3'b000;
      upd_sreg  <= 3'b000;
    end else begin
      seek_sreg <= {seek_sreg[1:0], addr_ext_write};
      upd_sreg  <= {upd_sreg[1:0], status_reset_we};
    end
  end

  // Rising edges only, payload is expected stable by now
  always_comb begin
    seek_d.valid = (seek_sreg[2:1] == 2'b01);
    seek_d.addr  = addr_ext;

    upd_d.valid      = (upd_sreg[2:1] == 2'b01);
    upd_d.set_bits   = status_set_bits;
    upd_d.reset_bits = status_reset_bits;
  end

  always_ff @(posedge clkin) begin
    if (!rst_n) begin
      seek       <= '0;
      status_upd <= '0;
    end else begin
      seek       <= seek_d;
      status_upd <= upd_d;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/msu_pkg.sv ====
`default_nettype none

`include "msu_settings.svh"

package msu_pkg;

  ////////////////////
  // Console side
  ////////////////////

  // One console access, pulses are a single cycle wide
  typedef struct packed {
    logic [2:0] addr;
    logic [7:0] data;
    logic       rd_start;  // /OE going low
    logic       rd_end;    // /OE going high
    logic       wr;        // Write strobe rising
  } msu_bus_t;

  ////////////////////
  // MCU side
  ////////////////////

  // Buffer seek from the file server
  typedef struct packed {
    logic                   valid;
    logic [`MSU_BUF_AW-1:0] addr;
  } msu_seek_t;

  // Status flag update
  // Bit 5 audio busy, 4 data busy, 3 audio error, 2:1 audio status, 0 ctrl start
  typedef struct packed {
    logic       valid;
    logic [5:0] set_bits;
    logic [5:0] reset_bits;
  } msu_status_upd_t;

  ////////////////////
  // Playback command
  ////////////////////

  typedef struct packed {
    logic [31:0] addr;          // Data file offset
    logic [15:0] track;
    logic [7:0]  volume;
    logic        volume_latch;  // One cycle after a volume write
  } msu_play_t;

endpackage

`default_nettype wire

// ==== verilog/msu_regs.sv ====
`default_nettype none

`include "msu_settings.svh"

module msu_regs (
  input  wire                            clkin,
  input  wire                            rst_n,
  input  wire                            enable,
  input  wire msu_pkg::msu_bus_t         bus,
  input  wire msu_pkg::msu_seek_t        seek,
  input  wire msu_pkg::msu_status_upd_t  status_upd,
  input  wire [7:0]                      buf_data,
  output logic [`MSU_BUF_AW-1:0]         buf_address,
  output logic [7:0]                     reg_data_out,
  output logic [7:0]                     status_out,
  output msu_pkg::msu_play_t             play
);

  // Flag positions, shared with the MCU update bits
  localparam int ST_AUDIO_BUSY = 5;
  localparam int ST_DATA_BUSY  = 4;
  localparam int ST_AUDIO_ERR  = 3;
  localparam int ST_CTRL_START = 0;

  logic       wr_en;
  logic       rd_en;
  logic       rd_done;
  logic [5:0] status_q;     // Bits 2:1 hold the audio status
  logic       audio_start;
  logic       data_start;
  logic [2:0] audio_ctrl;

  assign wr_en   = bus.wr & enable;
  assign rd_en   = bus.rd_start & enable;
  assign rd_done = bus.rd_end & enable & (bus.addr == 3'd1);  // Only data port reads advance

  ////////////////////
  // Writes and flags
  ////////////////////

  always_ff @(posedge clkin) begin
    if (!rst_n) begin
      status_q    <= 6'b110000;  // Both busy until the MCU clears them
      audio_start <= 1'b0;
      data_start  <= 1'b0;
      audio_ctrl  <= 3'd0;
      play        <= '0;
    end else begin
      play.volume_latch <= wr_en && (bus.addr == 3'd6);

      if (wr_en) begin
        case (bus.addr)
          3'd0: play.addr[7:0]   <= bus.data;
          3'd1: play.addr[15:8]  <= bus.data;
          3'd2: play.addr[23:16] <= bus.data;
          3'd3: begin
            // Top byte completes the address and kicks off the data fetch
            play.addr[31:24]       <= bus.data;
            data_start             <= 1'b1;
            status_q[ST_DATA_BUSY] <= 1'b1;
          end
          3'd4: play.track[7:0] <= bus.data;
          3'd5: begin
            play.track[15:8]        <= bus.data;
            audio_start             <= 1'b1;
            status_q[ST_AUDIO_BUSY] <= 1'b1;
          end
          3'd6: play.volume <= bus.data;
          3'd7: begin
            // Control is locked out while a track is loading
            if (!status_q[ST_AUDIO_BUSY]) begin
              audio_ctrl              <= bus.data[2:0];
              status_q[ST_CTRL_START] <= 1'b1;
            end
          end
        endcase
      end else if (status_upd.valid) begin
        status_q <= (status_q | status_upd.set_bits) & ~status_upd.reset_bits;
        if (status_upd.reset_bits[ST_AUDIO_BUSY]) begin
          audio_start <= 1'b0;
        end
        if (status_upd.reset_bits[ST_DATA_BUSY]) begin
          data_start <= 1'b0;
        end
      end
    end
  end

  ////////////////////
  // Reads
  ////////////////////

  // Held until the next read starts
  always_ff @(posedge clkin) begin
    if (!rst_n) begin
      reg_data_out <= 8'h00;
    end else if (rd_en) begin
      case (bus.addr)
        3'd0: reg_data_out <= {status_q[ST_DATA_BUSY],
                               status_q[ST_AUDIO_BUSY],
                               status_q[2:1],
                               status_q[ST_AUDIO_ERR],
                               `MSU_REVISION};
        3'd1: reg_data_out <= buf_data;  // Word at the current address
        3'd2: reg_data_out <= `MSU_ID0;
        3'd3: reg_data_out <= `MSU_ID1;
        3'd4: reg_data_out <= `MSU_ID2;
        3'd5: reg_data_out <= `MSU_ID3;
        3'd6: reg_data_out <= `MSU_ID4;
        3'd7: reg_data_out <= `MSU_ID5;
      endcase
    end
  end

  ////////////////////
  // Buffer address
  ////////////////////

  always_ff @(posedge clkin) begin
    if (!rst_n) begin
      buf_address <= '0;
    end else if (seek.valid) begin
      buf_address <= seek.addr;  // Seek wins over a read in the same cycle
    end else if (rd_done) begin
      buf_address <= buf_address + 1'b1;  // Wraps at the buffer end
    end
  end

  // Status word toward the MCU
  assign status_out = {buf_address[`MSU_BUF_AW-1],
                       audio_start,
                       data_start,
                       play.volume_latch,
                       audio_ctrl,
                       status_q[ST_CTRL_START]};

endmodule

`default_nettype wire

// ==== verilog/msu_settings.svh ====
`ifndef MSU_SETTINGS_SVH
`define MSU_SETTINGS_SVH

////////////////////
// Data buffer
////////////////////

// 16 KiB of streaming data
`define MSU_BUF_AW 14

////////////////////
// Identification
////////////////////

// Low bits of register 0
`define MSU_REVISION 3'd1

// "S-MSU1" on registers 2 to 7
`define MSU_ID0 8'h53
`define MSU_ID1 8'h2d
`define MSU_ID2 8'h4d
`define MSU_ID3 8'h53
`define MSU_ID4 8'h55
`define MSU_ID5 8'h31

`endif

// ==== verilog/msu_top.sv ====
`default_nettype none

`include "msu_settings.svh"

module msu_top (
  input  wire                     clkin,
  input  wire                     rst_n,
  input  wire                     enable,
  input  wire                     reg_oe,
  input  wire                     reg_we,
  input  wire [2:0]               reg_addr,
  input  wire [7:0]               reg_data_in,
  output wire [7:0]               reg_data_out,
  input  wire [`MSU_BUF_AW-1:0]   pgm_address,
  input  wire [7:0]               pgm_data,
  input  wire                     pgm_we,
  input  wire [`MSU_BUF_AW-1:0]   addr_ext,
  input  wire                     addr_ext_write,
  input  wire [5:0]               status_set_bits,
  input  wire [5:0]               status_reset_bits,
  input  wire                     status_reset_we,
  output wire [7:0]               status_out,
  output wire msu_pkg::msu_play_t play
);

  import msu_pkg::*;

  msu_bus_t               bus;
  msu_seek_t              seek;
  msu_status_upd_t        status_upd;
  wire [`MSU_BUF_AW-1:0]  buf_address;
  wire [7:0]              buf_data;

  ////////////////////
  // Input stages
  ////////////////////

  msu_bus_edge i_bus_edge (
    .clkin       (clkin),
    .rst_n       (rst_n),
    .reg_oe      (reg_oe),
    .reg_we      (reg_we),
    .reg_addr    (reg_addr),
    .reg_data_in (reg_data_in),
    .bus         (bus)
  );

  msu_mcu_sync i_mcu_sync (
    .clkin             (clkin),
    .rst_n             (rst_n),
    .addr_ext_write    (addr_ext_write),
    .addr_ext          (addr_ext),
    .status_reset_we   (status_reset_we),
    .status_set_bits   (status_set_bits),
    .status_reset_bits (status_reset_bits),
    .seek              (seek),
    .status_upd        (status_upd)
  );

  ////////////////////
  // Registers and buffer
  ////////////////////

  msu_regs i_regs (
    .clkin        (clkin),
    .rst_n        (rst_n),
    .enable       (enable),
    .bus          (bus),
    .seek         (seek),
    .status_upd   (status_upd),
    .buf_data     (buf_data),
    .buf_address  (buf_address),
    .reg_data_out (reg_data_out),
    .status_out   (status_out),
    .play         (play)
  );

  msu_databuf i_databuf (
    .clkin       (clkin),
    .pgm_we      (pgm_we),
    .pgm_address (pgm_address),
    .pgm_data    (pgm_data),
    .rd_address  (buf_address),
    .rd_data     (buf_data)
  );

endmodule

`default_nettype wire
